// ==== source/cpu_pkg.sv ====
/*
 * Shared types and constants for the 16-bit 65Org16-style core.
 * Every RTL module imports this package with a wildcard import in its header.
 * Opcode constants give the low byte; bits 9:8 select the accumulator.
 */
package cpu_pkg;

	typedef logic [15:0] word_t;	// Data word and opcode width

	typedef struct packed {
		word_t hi;	// Page half of the address
		word_t lo;	// Offset within the page
	} addr_t;

	typedef enum logic [1:0] {ACC_A, ACC_B, ACC_C, ACC_D} acc_sel_t;

	typedef enum logic [3:0] {
		DECODE,	// Opcode on rdata, write back previous result
		FETCH,	// Run pending ALU op, read next opcode
		REG,	// Register transfers and flag ops
		ABS0,	// Fetch address low word
		ABS1,	// Fetch address high word, store happens here
		BRA0,	// Fetch offset, add to PC low
		BRA1,	// Fetch target if same page
		BRA2,	// Fetch target after page crossing
		JMP0,	// Fetch target low word
		JMP1	// Fetch target high word
	} cpu_state_t;

	typedef enum logic [3:0] {
		OP_OR  = 4'b1100,
		OP_AND = 4'b1101,
		OP_EOR = 4'b1110,
		OP_ADD = 4'b0011,
		OP_SUB = 4'b0111,	// Adds inverted bi
		OP_A   = 4'b1111	// Pass ai
	} alu_op_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} flags_t;

	typedef struct packed {
		alu_op_t op;	// ALU op for FETCH or REG
		acc_sel_t dst;	// Accumulator written in DECODE
		acc_sel_t src;	// Left operand, transfer or store source
		logic load_reg;	// Result goes to dst
		logic load_only;	// LDA, left operand forced to zero
		logic store;	// STA
		logic adc_sbc;	// Updates C and V
		logic compare;	// CMP, flags only
		logic clc;
		logic sec;
		logic [2:0] cond_code;	// Branch condition, IR bits 7:5
		logic backwards;	// Sign of branch offset
	} decoded_t;

	typedef struct packed {
		alu_op_t op;
		word_t ai;
		word_t bi;
		logic ci;
	} alu_in_t;

	typedef struct packed {
		word_t out;
		logic co;
		logic v;
		logic n;
	} alu_result_t;

	localparam word_t ORA_IMM  = 16'h0009;
	localparam word_t ORA_ABS  = 16'h000d;
	localparam word_t AND_IMM  = 16'h0029;
	localparam word_t AND_ABS  = 16'h002d;
	localparam word_t EOR_IMM  = 16'h0049;
	localparam word_t EOR_ABS  = 16'h004d;
	localparam word_t ADC_IMM  = 16'h0069;
	localparam word_t ADC_ABS  = 16'h006d;
	localparam word_t STA_ABS  = 16'h008d;
	localparam word_t LDA_IMM  = 16'h00a9;
	localparam word_t LDA_ABS  = 16'h00ad;
	localparam word_t CMP_IMM  = 16'h00c9;
	localparam word_t CMP_ABS  = 16'h00cd;
	localparam word_t SBC_IMM  = 16'h00e9;
	localparam word_t SBC_ABS  = 16'h00ed;
	localparam word_t TRANSFER = 16'h008b;	// Source in bits 5:4
	localparam word_t BPL      = 16'h0010;
	localparam word_t BMI      = 16'h0030;
	localparam word_t BVC      = 16'h0050;
	localparam word_t BVS      = 16'h0070;
	localparam word_t BCC      = 16'h0090;
	localparam word_t BCS      = 16'h00b0;
	localparam word_t BNE      = 16'h00d0;
	localparam word_t BEQ      = 16'h00f0;
	localparam word_t JMP_ABS  = 16'h004c;
	localparam word_t CLC      = 16'h0018;
	localparam word_t SEC      = 16'h0038;

endpackage

// ==== source/alu.sv ====
/*
 * Registered 16-bit ALU. Output word, carry, overflow and sign are
 * available one cycle after the inputs.
 * OP_SUB adds the inverted right operand, so ci=1 gives a plain subtract.
 */
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
	input logic clk,
	input alu_in_t alu_in,
	output alu_result_t result
);

	word_t bi_eff;	// Right operand after inversion
	logic [16:0] sum;
	word_t out_c;
	logic arith;

	assign arith = (alu_in.op == OP_ADD) || (alu_in.op == OP_SUB);
	assign bi_eff = (alu_in.op == OP_SUB) ? ~alu_in.bi : alu_in.bi;
	assign sum = {1'b0, alu_in.ai} + {1'b0, bi_eff} + {16'b0, alu_in.ci};

	always_comb begin
		case (alu_in.op)
			OP_OR: out_c = alu_in.ai | alu_in.bi;
			OP_AND: out_c = alu_in.ai & alu_in.bi;
			OP_EOR: out_c = alu_in.ai ^ alu_in.bi;
			OP_A: out_c = alu_in.ai;
			default: out_c = sum[15:0];	// OP_ADD, OP_SUB
		endcase
	end

	always_ff @(posedge clk) begin
		result.out <= out_c;
		result.co <= arith && sum[16];	// No carry from logic ops
		result.v <= (alu_in.ai[15] == bi_eff[15]) && (sum[15] != alu_in.ai[15]);
		result.n <= out_c[15];
	end

endmodule

// ==== source/sequencer.sv ====
/*
 * Microcode FSM and instruction decoder. The opcode is decoded in DECODE
 * into ctrl, which stays valid until the next DECODE, so the ALU op of one
 * instruction runs while the next one is fetched.
 */
`timescale 1ns/1ns

module sequencer import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t rdata,
	input flags_t flags,
	input alu_result_t result,
	output cpu_state_t state,
	output decoded_t ctrl
);

	word_t low_op;	// Opcode with the accumulator bits masked off
	cpu_state_t dec_next;
	decoded_t dec_ctrl;
	logic alu_grp;	// ORA..SBC column, imm or abs
	logic cond_true;

	assign low_op = {8'h00, rdata[7:0]};

	always_comb begin
		dec_ctrl = '0;
		dec_ctrl.op = OP_ADD;
		dec_ctrl.dst = acc_sel_t'(rdata[9:8]);
		dec_ctrl.src = ACC_A;	// ALU ops always take A on the left
		dec_ctrl.cond_code = rdata[7:5];
		dec_next = REG;	// Unknown opcodes idle through REG
		alu_grp = 1'b0;
		if (rdata[15:10] == 6'b0) begin
			if (low_op inside {ORA_IMM, AND_IMM, EOR_IMM, ADC_IMM,
					LDA_IMM, CMP_IMM, SBC_IMM}) begin
				dec_next = FETCH;
				alu_grp = 1'b1;
			end else if (low_op inside {ORA_ABS, AND_ABS, EOR_ABS, ADC_ABS,
					STA_ABS, LDA_ABS, CMP_ABS, SBC_ABS}) begin
				dec_next = ABS0;
				alu_grp = 1'b1;
			end else if ((low_op & 16'hffcf) == TRANSFER) begin
				dec_ctrl.op = OP_A;	// Pass the source through
				dec_ctrl.load_reg = 1'b1;
				dec_ctrl.src = acc_sel_t'(rdata[5:4]);	// Source accumulator
			end else if (rdata[9:8] == 2'b00) begin
				if (low_op inside {BPL, BMI, BVC, BVS, BCC, BCS, BNE, BEQ})
					dec_next = BRA0;
				else if (low_op == JMP_ABS)
					dec_next = JMP0;
				dec_ctrl.clc = (low_op == CLC);
				dec_ctrl.sec = (low_op == SEC);
			end
		end
		if (alu_grp) begin
			case (rdata[7:5])
				3'b000: dec_ctrl.op = OP_OR;
				3'b001: dec_ctrl.op = OP_AND;
				3'b010: dec_ctrl.op = OP_EOR;
				3'b011: dec_ctrl.adc_sbc = 1'b1;	// ADC
				3'b100: dec_ctrl.src = acc_sel_t'(rdata[9:8]);	// STA source
				3'b101: dec_ctrl.load_only = 1'b1;	// LDA
				3'b110: dec_ctrl.op = OP_SUB;	// CMP
				default: begin	// SBC
					dec_ctrl.op = OP_SUB;
					dec_ctrl.adc_sbc = 1'b1;
				end
			endcase
			dec_ctrl.store = (rdata[7:5] == 3'b100);
			dec_ctrl.compare = (rdata[7:5] == 3'b110);
			dec_ctrl.load_reg = !dec_ctrl.store && !dec_ctrl.compare;
		end
	end

	always_comb begin
		case (ctrl.cond_code)
			3'b000: cond_true = ~flags.n;
			3'b001: cond_true = flags.n;
			3'b010: cond_true = ~flags.v;
			3'b011: cond_true = flags.v;
			3'b100: cond_true = ~flags.c;
			3'b101: cond_true = flags.c;
			3'b110: cond_true = ~flags.z;
			default: cond_true = flags.z;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= FETCH;	// Fetch opcode at reset_vector
		end else begin
			case (state)
				DECODE: state <= dec_next;
				ABS0: state <= ABS1;
				ABS1: state <= FETCH;
				BRA0: state <= cond_true ? BRA1 : DECODE;
				BRA1: state <= (result.co ^ ctrl.backwards) ? BRA2 : DECODE;	// Page cross
				JMP0: state <= JMP1;
				default: state <= DECODE;	// FETCH, REG, BRA2, JMP1
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ctrl <= '0;
		else if (state == DECODE)
			ctrl <= dec_ctrl;
		else if (state == BRA0)
			ctrl.backwards <= rdata[15];	// Offset sign arrives in BRA0
	end

	state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {DECODE, FETCH, REG, ABS0, ABS1, BRA0, BRA1, BRA2, JMP0, JMP1});

	store_not_load: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.store && ctrl.load_reg));

endmodule

// ==== source/address_gen.sv ====
/*
 * Program counter and address bus multiplexer. The PC is loaded with a
 * base value plus an optional increment each cycle. abl and abh keep the
 * previous bus address for the REG and branch paths.
 */
`timescale 1ns/1ns

module address_gen import cpu_pkg::*; #(
	parameter addr_t reset_vector = 32'h0000_0000
) (
	input logic clk,
	input logic reset,
	input cpu_state_t state,
	input decoded_t ctrl,
	input word_t rdata,
	input alu_result_t result,
	output addr_t addr
);

	addr_t pc;
	addr_t pc_temp;	// Base for the next PC
	logic pc_inc;
	word_t abl;	// Previous address, low word
	word_t abh;	// Previous address, high word

	always_comb begin
		pc_temp = pc;
		pc_inc = 1'b0;
		case (state)
			DECODE, FETCH, ABS0, BRA0: pc_inc = 1'b1;
			BRA1: begin
				pc_temp = {abh, result.out};
				pc_inc = ~(result.co ^ ctrl.backwards);	// Hold if page changes
			end
			BRA2: begin
				pc_temp = {result.out, pc.lo};	// Corrected page from ALU
				pc_inc = 1'b1;
			end
			JMP1: begin
				pc_temp = {rdata, result.out};
				pc_inc = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= reset_vector;
		else
			pc <= pc_temp + {31'b0, pc_inc};
	end

	always_comb begin
		addr = pc;
		case (state)
			DECODE, FETCH, ABS0, BRA0, JMP0: addr = pc;
			ABS1, JMP1: addr = {rdata, result.out};	// High word arrives now
			BRA1: addr = {abh, result.out};	// Same page target
			BRA2: addr = {result.out, abl};	// Next or previous page
			REG: addr = {abh, abl};	// Re-read next opcode
			default: addr = pc;
		endcase
	end

	always_ff @(posedge clk) begin
		abl <= addr.lo;
		abh <= addr.hi;
	end

	abs_addr: assert property (@(posedge clk) disable iff (reset)
		state == ABS1 |-> addr == {rdata, $past(rdata)});

endmodule

// ==== source/datapath.sv ====
/*
 * Accumulators A to D, status flags, ALU operand selection and store data.
 * Results and flags are written in DECODE from the registered ALU output.
 * Store data is driven only while we is high.
 */
`timescale 1ns/1ns

module datapath import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input cpu_state_t state,
	input decoded_t ctrl,
	input word_t rdata,
	input addr_t addr,	// PC low in BRA0, old page in BRA1
	input alu_result_t result,
	output alu_in_t alu_in,
	output flags_t flags,
	output word_t wdata,
	output logic we
);

	word_t acc [4];	// A, B, C, D

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				acc[i] <= '0;
		end else if (state == DECODE && ctrl.load_reg) begin
			acc[ctrl.dst] <= result.out;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags <= '0;
		end else if (state == DECODE) begin
			if (ctrl.adc_sbc || ctrl.compare)
				flags.c <= result.co;
			else if (ctrl.sec)
				flags.c <= 1'b1;
			else if (ctrl.clc)
				flags.c <= 1'b0;
			if (ctrl.load_reg || ctrl.compare) begin
				flags.z <= (result.out == '0);
				flags.n <= result.n;
			end
			if (ctrl.adc_sbc)
				flags.v <= result.v;
		end
	end

	always_comb begin
		alu_in.op = OP_ADD;	// Default passes rdata through
		alu_in.ai = '0;
		alu_in.bi = rdata;
		alu_in.ci = 1'b0;
		case (state)
			FETCH: begin
				alu_in.op = ctrl.op;
				alu_in.ai = ctrl.load_only ? '0 : acc[ctrl.src];
				alu_in.ci = ctrl.compare ? 1'b1 : (!ctrl.load_only && flags.c);
			end
			REG: begin
				alu_in.op = ctrl.op;
				alu_in.ai = acc[ctrl.src];	// Transfer source
			end
			BRA0: begin
				alu_in.ai = rdata;	// Offset
				alu_in.bi = addr.lo;	// PC after the offset word
			end
			BRA1: begin
				alu_in.op = ctrl.backwards ? OP_SUB : OP_ADD;
				alu_in.ai = addr.hi;
				alu_in.bi = '0;
				alu_in.ci = result.co;	// Page carry or borrow
			end
			default: ;
		endcase
	end

	assign we = (state == ABS1) && ctrl.store;
	assign wdata = we ? acc[ctrl.src] : '0;

	we_in_abs1: assert property (@(posedge clk) disable iff (reset)
		we |-> state == ABS1 && $past(state) == ABS0);

endmodule

// ==== source/cpu_core.sv ====
/*
 * Top level of the 16-bit core. Connects sequencer, address generator,
 * datapath and ALU to one synchronous memory port.
 * Execution starts at reset_vector after reset, no vector fetch.
 */
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; #(
	parameter addr_t reset_vector = 32'h0000_0000
) (
	input logic clk,
	input logic reset,
	output addr_t addr,	// Read data returns one cycle later
	input word_t rdata,
	output word_t wdata,
	output logic we	// Write at this clock edge
);

	cpu_state_t state;
	decoded_t ctrl;
	flags_t flags;
	alu_in_t alu_in;
	alu_result_t result;	// Registered ALU output

	sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.rdata(rdata),
		.flags(flags),
		.result(result),
		.state(state),
		.ctrl(ctrl)
	);

	address_gen #(.reset_vector(reset_vector)) u_address_gen (
		.clk(clk),
		.reset(reset),
		.state(state),
		.ctrl(ctrl),
		.rdata(rdata),
		.result(result),
		.addr(addr)
	);

	datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.state(state),
		.ctrl(ctrl),
		.rdata(rdata),
		.addr(addr),	// PC halves for branch arithmetic
		.result(result),
		.alu_in(alu_in),
		.flags(flags),
		.wdata(wdata),
		.we(we)
	);

	alu u_alu (
		.clk(clk),
		.alu_in(alu_in),
		.result(result)
	);

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * Free-running testbench clock, low at time zero.
 */
`timescale 1ns/1ns

module tb_clock #(
	parameter int period = 10	// In ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

// ==== testbench/cpu_tb.sv ====
/*
 * Testbench for cpu_core. Builds a random program from a fixed seed,
 * runs it through a reference interpreter to get the expected stores,
 * and compares every DUT write against that list on the falling edge.
 */
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

	localparam addr_t start_addr = 32'h0000_fff0;	// Page edge, first branch crosses
	localparam int mem_words = 131072;	// Pages 0 and 1

	logic clk;
	logic reset = 1'b1;
	addr_t addr;
	word_t rdata = '0;
	word_t wdata;
	logic we;

	word_t image [mem_words];	// Program and data as loaded
	word_t mem [mem_words];	// Memory seen by the DUT
	word_t ref_mem [mem_words];	// Interpreter copy
	logic image_ready = 1'b0;
	addr_t addr_q = '0;
	logic we_q = 1'b0;
	word_t wdata_q = '0;

	addr_t exp_addr [$];
	word_t exp_data [$];
	integer seed;
	logic [31:0] gen_ptr;
	int instr_count;
	int store_count = 0;
	int mismatch_count = 0;
	int other_errors = 0;
	int cycles;
	int limit;
	logic start_checked = 1'b0;

	tb_clock #(.period(10)) u_clock (.clk(clk));

	cpu_core #(.reset_vector(start_addr)) uut (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.rdata(rdata),
		.wdata(wdata),
		.we(we)
	);

	function automatic int unsigned mem_index(input logic [31:0] a);
		return {15'b0, a[16:0]};
	endfunction

	function automatic word_t next_rand();
		integer r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic void emit(input word_t w);
		image[mem_index(gen_ptr)] = w;
		gen_ptr = gen_ptr + 32'd1;
	endfunction

	function automatic word_t with_acc(input word_t base, input logic [1:0] a);
		return base | {6'b0, a, 8'h00};	// Accumulator in bits 9:8
	endfunction

	function automatic void emit_abs(input word_t op);
		word_t r;
		r = next_rand();
		emit(op);
		emit(16'h4000 | {12'h000, r[3:0]});	// 16-word data area
		emit(16'h0000);
		instr_count++;
	endfunction

	function automatic void emit_branch(input logic [2:0] cond);
		word_t r;
		emit({8'h00, cond, 5'h10});
		emit(16'h0003);	// Skip exactly one STA
		instr_count++;
		r = next_rand();
		emit_abs(with_acc(STA_ABS, r[1:0]));
	endfunction

	function automatic word_t alu_imm(input int k);
		case (k)
			0: return ORA_IMM;
			1: return AND_IMM;
			2: return EOR_IMM;
			3: return ADC_IMM;
			4: return LDA_IMM;
			5: return CMP_IMM;
			default: return SBC_IMM;
		endcase
	endfunction

	function automatic void generate_program();
		word_t w;
		word_t op;
		logic [1:0] d;
		logic [31:0] loop_at;
		for (int i = 0; i < mem_words; i++)
			image[i] = word_t'(i * 40503) ^ word_t'(i >> 7);	// Depends on all 17 bits
		gen_ptr = start_addr;
		instr_count = 0;
		for (int a = 0; a < 4; a++) begin
			emit(with_acc(LDA_IMM, 2'(a)));
			emit(next_rand());
			instr_count++;
		end
		emit(CLC);
		emit(SEC);
		emit(BCS);
		emit(16'h0004);	// Target 0x0001_0000
		instr_count += 3;
		emit_abs(STA_ABS);	// Only reached if BCS falls through
		emit(CLC);
		instr_count++;
		for (int a = 0; a < 4; a++)
			emit_abs(with_acc(STA_ABS, 2'(a)));
		for (int s = 0; s < 4; s++) begin	// Every ordered pair
			for (int t = 0; t < 4; t++) begin
				if (s != t) begin
					emit(with_acc(LDA_IMM, 2'(s)));
					emit(next_rand());
					emit(with_acc(TRANSFER | {10'h000, 2'(s), 4'h0}, 2'(t)));
					instr_count += 2;
					emit_abs(with_acc(STA_ABS, 2'(t)));
				end
			end
		end
		for (int i = 0; i < 24; i++) begin
			w = next_rand();
			d = w[5:4];
			op = alu_imm(int'(w[10:8]) % 7);
			case (w[2:0])
				3'd0, 3'd1: begin
					emit(with_acc(op, d));
					emit(next_rand());
					instr_count++;
					if (op != CMP_IMM)
						emit_abs(with_acc(STA_ABS, d));
				end
				3'd2: begin
					emit_abs(with_acc(op | 16'h0004, d));	// Absolute form
					if (op != CMP_IMM)
						emit_abs(with_acc(STA_ABS, d));
				end
				3'd3: begin
					emit(with_acc(TRANSFER | {10'h000, w[7:6], 4'h0}, d));
					instr_count++;
					emit_abs(with_acc(STA_ABS, d));
				end
				3'd4: begin
					emit(w[3] ? SEC : CLC);
					instr_count++;
				end
				3'd5: begin
					emit(CMP_IMM);
					emit(next_rand());
					instr_count++;
					emit_branch(w[13:11]);
				end
				default: emit_branch(w[13:11]);
			endcase
		end
		loop_at = gen_ptr;
		emit(JMP_ABS);	// Jump to itself
		emit(loop_at[15:0]);
		emit(loop_at[31:16]);
		instr_count++;
	endfunction

	function automatic word_t rd(input logic [31:0] a);
		return ref_mem[mem_index(a)];
	endfunction

	// Reference interpreter, fills the expected store list
	function automatic void run_reference();
		logic [31:0] pc;
		logic [31:0] ea;
		word_t ra [4];
		word_t op;
		word_t low;
		word_t base;
		word_t m;
		word_t r;
		logic [16:0] s;
		logic [1:0] d;
		logic c, z, n, v;
		logic take;
		logic done;
		int steps;
		for (int i = 0; i < mem_words; i++)
			ref_mem[i] = image[i];
		for (int i = 0; i < 4; i++)
			ra[i] = '0;
		{c, z, n, v} = 4'b0000;	// Reset state
		pc = start_addr;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 100000) begin
			steps++;
			op = rd(pc);
			low = {8'h00, op[7:0]};
			base = low & 16'hfffb;	// Absolute form folded onto immediate
			d = op[9:8];
			if (low == STA_ABS) begin
				ea = {rd(pc + 2), rd(pc + 1)};
				exp_addr.push_back(ea);
				exp_data.push_back(ra[d]);
				ref_mem[mem_index(ea)] = ra[d];
				pc = pc + 3;
			end else if (base inside {ORA_IMM, AND_IMM, EOR_IMM, ADC_IMM, LDA_IMM,
					CMP_IMM, SBC_IMM}) begin
				if (low == base) begin
					m = rd(pc + 1);
					pc = pc + 2;
				end else begin
					m = rd({rd(pc + 2), rd(pc + 1)});
					pc = pc + 3;
				end
				case (base)
					ORA_IMM: r = ra[0] | m;
					AND_IMM: r = ra[0] & m;
					EOR_IMM: r = ra[0] ^ m;
					LDA_IMM: r = m;
					ADC_IMM: begin
						s = {1'b0, ra[0]} + {1'b0, m} + {16'h0000, c};
						r = s[15:0];
						v = (ra[0][15] == m[15]) && (r[15] != ra[0][15]);
						c = s[16];
					end
					CMP_IMM: begin	// Subtract without borrow
						s = {1'b0, ra[0]} + {1'b0, ~m} + 17'd1;
						r = s[15:0];
						c = s[16];
					end
					default: begin	// SBC, borrow is not C
						s = {1'b0, ra[0]} + {1'b0, ~m} + {16'h0000, c};
						r = s[15:0];
						v = (ra[0][15] != m[15]) && (r[15] != ra[0][15]);
						c = s[16];
					end
				endcase
				if (base != CMP_IMM)
					ra[d] = r;
				n = r[15];
				z = (r == '0);
			end else if ((low & 16'hffcf) == TRANSFER) begin
				ra[d] = ra[op[5:4]];
				n = ra[d][15];
				z = (ra[d] == '0);
				pc = pc + 1;
			end else if (low inside {BPL, BMI, BVC, BVS, BCC, BCS, BNE, BEQ}) begin
				case (low)
					BPL: take = !n;
					BMI: take = n;
					BVC: take = !v;
					BVS: take = v;
					BCC: take = !c;
					BCS: take = c;
					BNE: take = !z;
					default: take = z;
				endcase
				m = rd(pc + 1);
				pc = pc + 2;
				if (take)
					pc = pc + {{16{m[15]}}, m};	// Relative to word after offset
			end else if (low == JMP_ABS) begin
				ea = {rd(pc + 2), rd(pc + 1)};
				done = (ea == pc);
				pc = ea;
			end else begin
				if (low == CLC)
					c = 1'b0;
				else if (low == SEC)
					c = 1'b1;
				pc = pc + 1;	// Anything else is a no-op
			end
		end
	endfunction

	// Synchronous memory, answers 1 ns after the edge
	initial begin
		wait (image_ready);
		for (int i = 0; i < mem_words; i++)
			mem[i] = image[i];
		forever begin
			@(posedge clk);
			#1;
			if (we_q)
				mem[mem_index(addr_q)] = wdata_q;
			rdata = mem[mem_index(addr_q)];
		end
	end

	// Store checker, samples the bus mid-cycle
	always @(negedge clk) begin
		addr_q = addr;
		we_q = we;
		wdata_q = wdata;
		if (reset) begin
			assert (!we) else begin
				other_errors++;
				$display("write enable high during reset at %0t", $time);
			end
		end else begin
			if (!start_checked) begin
				start_checked = 1'b1;
				assert (addr == start_addr) else begin
					mismatch_count++;
					$display("mismatch at %0t: first address %h, expected %h",
						$time, addr, start_addr);
				end
			end
			if (we) begin
				if (store_count < exp_data.size()) begin
					assert (addr == exp_addr[store_count] && wdata == exp_data[store_count])
					else begin
						mismatch_count++;
						$display("mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
							$time, store_count, wdata, addr,
							exp_data[store_count], exp_addr[store_count]);
					end
				end else begin
					other_errors++;
					$display("unexpected extra store at %0t to %h", $time, addr);
				end
				store_count++;
			end
		end
	end

	initial begin
		seed = 13629;
		generate_program();
		run_reference();
		image_ready = 1'b1;
		limit = instr_count * 4 + 100;
		cycles = 0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		while (store_count < exp_data.size() && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (store_count < exp_data.size()) begin
			other_errors++;
			$display("timeout after %0d cycles, saw %0d of %0d stores",
				cycles, store_count, exp_data.size());
		end else begin
			repeat (40) @(posedge clk);	// Self-JMP loop must stay quiet
		end
		assert (store_count == exp_data.size()) else begin
			other_errors++;
			$display("store count %0d differs from expected %0d", store_count, exp_data.size());
		end
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
source/cpu_pkg.sv
source/alu.sv
source/sequencer.sv
source/address_gen.sv
source/datapath.sv
source/cpu_core.sv
testbench/tb_clock.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
